/* sim.f */
+incdir+common
common/intraPkg.sv
common/picPkg.sv
leftNeighbor/leftModeFetch.sv
upperNeighbor/modeLineRam.sv
upperNeighbor/upperModeFetch.sv
verilog/modePredCombiner.sv
verilog/intraModeDecoder.sv
verification/tbIntraModeDecoder.sv

/* verification/tbIntraModeDecoder.sv */
// testbench for the intra 4x4 mode decoder, random block stream checked against a raster mode model
`timescale 1ns/100ps
`include "intra_consts.svh"

module tbIntraModeDecoder;

	localparam int CLK_PERIOD     = 100;
	localparam int PICTURES       = 2;
	localparam int BLOCKS_PER_PIC = `MB_COLS * `MB_ROWS * 16;
	localparam int CYCLES_PER_BLK = 6;  // 2 handshake plus up to 3 idle, rounded up
	localparam longint WATCHDOG_NS =
		longint'(PICTURES * BLOCKS_PER_PIC * CYCLES_PER_BLK + 200) * CLK_PERIOD;

	logic                clk;
	logic                reset_n;
	logic                blkValid;
	logic                blkReady;
	intraPkg::blkIdx_t   blkIdx;
	picPkg::mbNumH_t     mbNumH;
	picPkg::mbNumV_t     mbNumV;
	logic                prevFlag;
	intraPkg::remMode_t  remMode;
	intraPkg::mbType_t   mbType;
	logic                constrainedIntra;
	logic                modeValid;
	intraPkg::predMode_t modeOut;
	intraPkg::blkIdx_t   blkIdxOut;
	intraPkg::mbModes_t  currMbModes;

	integer              seed;
	int                  modeErrors;
	int                  hsErrors;
	int                  resetErrors;
	logic                acc1;  // accept edge follows the previous negedge
	logic                acc2;

	//----------------------------------------
	// reference model state
	//----------------------------------------
	intraPkg::predMode_t picModes [`MB_COLS * 4][`MB_ROWS * 4];  // raster x, y
	intraPkg::mbType_t   mbTypes [`MB_COLS][`MB_ROWS];
	intraPkg::mbModes_t  expMbVec;  // mirrors currMbModes, never cleared between mbs
	intraPkg::predMode_t expModeQ [$];
	intraPkg::blkIdx_t   expIdxQ [$];
	intraPkg::mbModes_t  expMbQ [$];

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	intraModeDecoder i_intraModeDecoder
	(
		.clk              (clk),
		.reset_n          (reset_n),
		.blkValid         (blkValid),
		.blkReady         (blkReady),
		.blkIdx           (blkIdx),
		.mbNumH           (mbNumH),
		.mbNumV           (mbNumV),
		.prevFlag         (prevFlag),
		.remMode          (remMode),
		.mbType           (mbType),
		.constrainedIntra (constrainedIntra),
		.modeValid        (modeValid),
		.modeOut          (modeOut),
		.blkIdxOut        (blkIdxOut),
		.currMbModes      (currMbModes)
	);

	// H.264 Intra4x4 rule on raster coordinates of the block
	function automatic intraPkg::predMode_t expectedMode(input int x, input int y,
		input logic cIntra, input logic prev, input intraPkg::remMode_t rem);
		int                mbH;
		int                mbV;
		int                a;
		int                b;
		int                pred;
		logic              dcA;
		logic              dcB;
		intraPkg::mbType_t nbType;
		mbH = x / 4;
		mbV = y / 4;
		a = 0;
		b = 0;
		dcA = 1'b0;
		dcB = 1'b0;
		if (x % 4 != 0)
			a = picModes[x - 1][y];
		else if (mbH == 0)
			dcA = 1'b1;  // left picture edge
		else
		begin
			nbType = mbTypes[mbH - 1][mbV];
			if (cIntra && (nbType < `MBT_INTRA4X4))
				dcA = 1'b1;
			else if (nbType != `MBT_INTRA4X4)
				a = `DC_PRED_MODE;
			else
				a = picModes[x - 1][y];
		end
		if (y % 4 != 0)
			b = picModes[x][y - 1];
		else if (mbV == 0)
			dcB = 1'b1;  // top picture edge
		else
		begin
			nbType = mbTypes[mbH][mbV - 1];
			if (cIntra && (nbType < `MBT_INTRA4X4))
				dcB = 1'b1;
			else if (nbType != `MBT_INTRA4X4)
				b = `DC_PRED_MODE;
			else
				b = picModes[x][y - 1];
		end
		pred = (dcA || dcB) ? `DC_PRED_MODE : ((a < b) ? a : b);
		if (prev)
			return intraPkg::predMode_t'(pred);
		else if (rem < pred)
			return intraPkg::predMode_t'(rem);
		else
			return intraPkg::predMode_t'(rem + 1);
	endfunction

	// push one block, with optional idle cycles, and return on its accept edge
	task automatic sendBlock(input int h, input int v, input int blk, input int typ);
		int                  idle;
		int                  x;
		int                  y;
		logic                pf;
		logic                ci;
		intraPkg::remMode_t  rm;
		intraPkg::predMode_t m;
		idle = $random(seed) & 7;
		pf = $random(seed) & 1;
		rm = $random(seed) & 7;
		ci = $random(seed) & 1;
		x = h * 4 + ((blk >> 2) & 1) * 2 + (blk & 1);
		y = v * 4 + ((blk >> 3) & 1) * 2 + ((blk >> 1) & 1);
		m = expectedMode(x, y, ci, pf, rm);
		picModes[x][y] = m;
		expMbVec[blk * 4 +: 4] = m;
		expModeQ.push_back(m);
		expIdxQ.push_back(intraPkg::blkIdx_t'(blk));
		expMbQ.push_back(expMbVec);
		if (idle > 4)
		begin
			blkValid <= 1'b0;
			repeat (idle - 4) @(posedge clk);
		end
		blkValid         <= 1'b1;
		blkIdx           <= intraPkg::blkIdx_t'(blk);
		mbNumH           <= picPkg::mbNumH_t'(h);
		mbNumV           <= picPkg::mbNumV_t'(v);
		prevFlag         <= pf;
		remMode          <= rm;
		mbType           <= intraPkg::mbType_t'(typ);
		constrainedIntra <= ci;
		forever
		begin
			@(negedge clk);
			if (blkReady)
				break;
		end
		@(posedge clk);  // accept edge
	endtask

	//----------------------------------------
	// main sequence
	//----------------------------------------
	initial
	begin
		seed = 86;
		modeErrors = 0;
		hsErrors = 0;
		resetErrors = 0;
		expMbVec = '0;
		reset_n          <= 1'b0;
		blkValid         <= 1'b0;
		blkIdx           <= '0;
		mbNumH           <= '0;
		mbNumV           <= '0;
		prevFlag         <= 1'b0;
		remMode          <= '0;
		mbType           <= '0;
		constrainedIntra <= 1'b0;
		repeat (15) @(posedge clk);
		@(negedge clk);
		if (blkReady !== 1'b1 || modeValid !== 1'b0 || currMbModes !== '0)
		begin
			resetErrors++;
			$display("reset values wrong at %0t ns: blkReady %b modeValid %b currMbModes %h",
				$time, blkReady, modeValid, currMbModes);
		end
		@(posedge clk);
		reset_n <= 1'b1;
		for (int p = 0; p < PICTURES; p++)
			for (int v = 0; v < `MB_ROWS; v++)
				for (int h = 0; h < `MB_COLS; h++)
				begin
					mbTypes[h][v] = $random(seed) & 3;
					for (int blk = 0; blk < 16; blk++)
						sendBlock(h, v, blk, mbTypes[h][v]);
				end
		blkValid <= 1'b0;
		while (expModeQ.size() != 0)
			@(negedge clk);
		repeat (4) @(posedge clk);
		$display("errors: %0d mode, %0d handshake, %0d reset", modeErrors, hsErrors, resetErrors);
		if (modeErrors + hsErrors + resetErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		intraPkg::predMode_t wantMode;
		intraPkg::blkIdx_t   wantIdx;
		intraPkg::mbModes_t  wantMb;
		if (!reset_n)
		begin
			acc1 = 1'b0;
			acc2 = 1'b0;
		end
		else
		begin
			if (modeValid !== acc2)
			begin
				hsErrors++;
				$display("handshake error at %0t ns: modeValid is %b two cycles after accept %b",
					$time, modeValid, acc2);
			end
			if (blkReady !== !acc1)
			begin
				hsErrors++;
				$display("handshake error at %0t ns: blkReady is %b while a block in flight is %b",
					$time, blkReady, acc1);
			end
			if (modeValid === 1'b1)
			begin
				if (expModeQ.size() == 0)
				begin
					hsErrors++;
					$display("handshake error at %0t ns: result with no block outstanding", $time);
				end
				else
				begin
					wantMode = expModeQ.pop_front();
					wantIdx  = expIdxQ.pop_front();
					wantMb   = expMbQ.pop_front();
					if (modeOut !== wantMode || blkIdxOut !== wantIdx)
					begin
						modeErrors++;
						$display("FAIL %0t ns: block %0d mode %0d, expected block %0d mode %0d",
							$time, blkIdxOut, modeOut, wantIdx, wantMode);
					end
					if (currMbModes !== wantMb)
					begin
						modeErrors++;
						$display("FAIL %0t ns: currMbModes %h, expected %h", $time, currMbModes,
							wantMb);
					end
				end
			end
			acc2 = acc1;
			acc1 = blkValid && blkReady;
		end
	end

	// watchdog, sized for the worst case block rate
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: block stream did not finish, %0d results still pending",
			expModeQ.size());
		$display("** FAIL **");
		$finish;
	end

endmodule

/* verilog/intraModeDecoder.sv */
// top of the intra 4x4 mode decoder, joins the left and upper fetch sides with the combiner
`timescale 1ns/100ps

module intraModeDecoder
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                blkValid,
	output logic                blkReady,
	input  intraPkg::blkIdx_t   blkIdx,
	input  picPkg::mbNumH_t     mbNumH,
	input  picPkg::mbNumV_t     mbNumV,
	input  logic                prevFlag,
	input  intraPkg::remMode_t  remMode,
	input  intraPkg::mbType_t   mbType,
	input  logic                constrainedIntra,
	output logic                modeValid,
	output intraPkg::predMode_t modeOut,
	output intraPkg::blkIdx_t   blkIdxOut,
	output intraPkg::mbModes_t  currMbModes
);

	logic                accept;
	intraPkg::predMode_t candA;
	logic                forceDcA;
	intraPkg::predMode_t candB;
	logic                forceDcB;

	leftModeFetch i_leftModeFetch
	(
		.clk              (clk),
		.reset_n          (reset_n),
		.accept           (accept),
		.blkIdx           (blkIdx),
		.mbNumH           (mbNumH),
		.mbType           (mbType),
		.constrainedIntra (constrainedIntra),
		.currMbModes      (currMbModes),
		.modeValid        (modeValid),
		.modeOut          (modeOut),
		.blkIdxOut        (blkIdxOut),
		.candA            (candA),
		.forceDcA         (forceDcA)
	);

	upperModeFetch i_upperModeFetch
	(
		.clk              (clk),
		.reset_n          (reset_n),
		.accept           (accept),
		.blkIdx           (blkIdx),
		.mbNumH           (mbNumH),
		.mbNumV           (mbNumV),
		.mbType           (mbType),
		.constrainedIntra (constrainedIntra),
		.currMbModes      (currMbModes),
		.modeValid        (modeValid),
		.modeOut          (modeOut),
		.blkIdxOut        (blkIdxOut),
		.candB            (candB),
		.forceDcB         (forceDcB)
	);

	modePredCombiner i_modePredCombiner
	(
		.clk         (clk),
		.reset_n     (reset_n),
		.blkValid    (blkValid),
		.blkReady    (blkReady),
		.accept      (accept),
		.blkIdx      (blkIdx),
		.prevFlag    (prevFlag),
		.remMode     (remMode),
		.candA       (candA),
		.forceDcA    (forceDcA),
		.candB       (candB),
		.forceDcB    (forceDcB),
		.modeValid   (modeValid),
		.modeOut     (modeOut),
		.blkIdxOut   (blkIdxOut),
		.currMbModes (currMbModes)
	);

endmodule

/* verilog/modePredCombiner.sv */
// combiner of the intra 4x4 mode decoder, forms the final mode and runs the block handshake
`timescale 1ns/100ps
`include "intra_consts.svh"

module modePredCombiner
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                blkValid,
	output logic                blkReady,
	output logic                accept,
	input  intraPkg::blkIdx_t   blkIdx,
	input  logic                prevFlag,
	input  intraPkg::remMode_t  remMode,
	input  intraPkg::predMode_t candA,
	input  logic                forceDcA,
	input  intraPkg::predMode_t candB,
	input  logic                forceDcB,
	output logic                modeValid,
	output intraPkg::predMode_t modeOut,
	output intraPkg::blkIdx_t   blkIdxOut,
	output intraPkg::mbModes_t  currMbModes
);

	typedef enum logic {hsIdle, hsBusy} hsState_t;

	hsState_t            state;
	intraPkg::blkIdx_t   curBlkIdx;
	logic                curPrevFlag;
	intraPkg::remMode_t  curRemMode;
	intraPkg::predMode_t remExt;
	intraPkg::predMode_t predMode;
	intraPkg::predMode_t finalMode;

	//----------------------------------------
	// handshake
	//----------------------------------------
	assign blkReady = (state == hsIdle);
	assign accept   = blkValid && blkReady;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			state <= hsIdle;
		else
		begin
			case (state)
				hsIdle:
				begin
					if (accept)
						state <= hsBusy;
				end
				hsBusy:  state <= hsIdle;  // result registered on this edge
				default: state <= hsIdle;
			endcase
		end
	end

	// syntax fields of the block in flight
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			curBlkIdx   <= blkIdx;
			curPrevFlag <= prevFlag;
			curRemMode  <= remMode;
		end
	end

	//----------------------------------------
	// mode derivation, stage 1
	//----------------------------------------
	always_comb
	begin
		if (forceDcA || forceDcB)
			predMode = intraPkg::predMode_t'(`DC_PRED_MODE);
		else if (candA < candB)
			predMode = candA;
		else
			predMode = candB;
	end

	assign remExt = {1'b0, curRemMode};

	// rem skips over the predicted mode
	assign finalMode = curPrevFlag ? predMode :
		((remExt < predMode) ? remExt : remExt + 4'd1);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			modeValid   <= 1'b0;
			currMbModes <= '0;
		end
		else
		begin
			modeValid <= (state == hsBusy);
			if (state == hsBusy)
				currMbModes[{curBlkIdx, 2'b00} +: 4] <= finalMode;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == hsBusy)
		begin
			modeOut   <= finalMode;
			blkIdxOut <= curBlkIdx;
		end
	end

	// one block in flight, so results never come back to back
	noBackToBack: assert property (@(posedge clk) disable iff (!reset_n)
		modeValid |=> !modeValid);

	// both fetch sides and the rem rule keep the mode in 0..8
	modeInRange: assert property (@(posedge clk) disable iff (!reset_n)
		modeValid |-> (modeOut <= 4'd8));

endmodule

/* upperNeighbor/upperModeFetch.sv */
// upper side of the intra 4x4 mode decoder, produces candidate B and refreshes the line buffer
`timescale 1ns/100ps
`include "intra_consts.svh"

module upperModeFetch
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                accept,
	input  intraPkg::blkIdx_t   blkIdx,
	input  picPkg::mbNumH_t     mbNumH,
	input  picPkg::mbNumV_t     mbNumV,
	input  intraPkg::mbType_t   mbType,
	input  logic                constrainedIntra,
	input  intraPkg::mbModes_t  currMbModes,
	input  logic                modeValid,
	input  intraPkg::predMode_t modeOut,
	input  intraPkg::blkIdx_t   blkIdxOut,
	output intraPkg::predMode_t candB,
	output logic                forceDcB
);

	intraPkg::blkIdx_t   curBlkIdx;
	picPkg::mbNumH_t     curMbNumH;
	picPkg::mbNumV_t     curMbNumV;
	intraPkg::mbType_t   curMbType;
	logic                curConstrained;
	picPkg::mbNumH_t     ramReadAddr;
	picPkg::lineWord_t   upperWord;
	picPkg::lineWord_t   ramWriteData;
	logic                ramWriteEn;
	intraPkg::mbType_t   upperType;
	logic                fromUpperMb;
	logic                upperIsInter;
	intraPkg::blkIdx_t   nbIdx;        // neighbour B inside the current mb
	intraPkg::predMode_t upperMode;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			curBlkIdx      <= '0;
			curMbNumH      <= '0;
			curMbNumV      <= '0;
			curMbType      <= '0;
			curConstrained <= 1'b0;
		end
		else if (accept)
		begin
			curBlkIdx      <= blkIdx;
			curMbNumH      <= mbNumH;
			curMbNumV      <= mbNumV;
			curMbType      <= mbType;
			curConstrained <= constrainedIntra;
		end
	end

	//----------------------------------------
	// line buffer access
	//----------------------------------------
	assign ramReadAddr = accept ? mbNumH : curMbNumH;  // entry is valid in stage 1

	// bottom row 10, 11, 14, 15 goes back once block 15 is out; last row has no reader
	assign ramWriteEn = modeValid && (blkIdxOut == 4'd15) &&
		(curMbNumV != picPkg::mbNumV_t'(`MB_ROWS - 1));
	assign ramWriteData = {currMbModes[43:40], currMbModes[47:44], currMbModes[59:56],
		modeOut, curMbType};

	modeLineRam i_modeLineRam
	(
		.clk       (clk),
		.reset_n   (reset_n),
		.readAddr  (ramReadAddr),
		.readData  (upperWord),
		.writeEn   (ramWriteEn),
		.writeAddr (curMbNumH),
		.writeData (ramWriteData)
	);

	//----------------------------------------
	// stage 1, candidate B
	//----------------------------------------
	assign upperType = upperWord[1:0];
	assign fromUpperMb = (curBlkIdx == 4'd0) || (curBlkIdx == 4'd1) ||
		(curBlkIdx == 4'd4) || (curBlkIdx == 4'd5);
	assign upperIsInter = (upperType == intraPkg::mbType_t'(`MBT_SKIP)) ||
		(upperType == intraPkg::mbType_t'(`MBT_INTER));
	assign forceDcB = fromUpperMb && ((curMbNumV == '0) || (curConstrained && upperIsInter));

	always_comb
	begin
		case ({curBlkIdx[2], curBlkIdx[0]})  // 0, 1, 4, 5 sit under 10, 11, 14, 15
			2'b00:   upperMode = upperWord[17:14];
			2'b01:   upperMode = upperWord[13:10];
			2'b10:   upperMode = upperWord[9:6];
			default: upperMode = upperWord[5:2];
		endcase
	end

	always_comb
	begin
		case (curBlkIdx)
			4'd2:    nbIdx = 4'd0;
			4'd3:    nbIdx = 4'd1;
			4'd6:    nbIdx = 4'd4;
			4'd7:    nbIdx = 4'd5;
			4'd8:    nbIdx = 4'd2;
			4'd9:    nbIdx = 4'd3;
			4'd10:   nbIdx = 4'd8;
			4'd11:   nbIdx = 4'd9;
			4'd12:   nbIdx = 4'd6;
			4'd13:   nbIdx = 4'd7;
			4'd14:   nbIdx = 4'd12;
			4'd15:   nbIdx = 4'd13;
			default: nbIdx = 4'd0;  // upper mb case
		endcase
	end

	always_comb
	begin
		if (!fromUpperMb)
			candB = currMbModes[{nbIdx, 2'b00} +: 4];
		else if (upperType != intraPkg::mbType_t'(`MBT_INTRA4X4))
			candB = intraPkg::predMode_t'(`DC_PRED_MODE);
		else
			candB = upperMode;
	end

endmodule

/* upperNeighbor/modeLineRam.sv */
// line buffer for the intra 4x4 mode decoder, one entry per macroblock column with registered read
`timescale 1ns/100ps
`include "intra_consts.svh"

module modeLineRam
(
	input  logic              clk,
	input  logic              reset_n,
	input  picPkg::mbNumH_t   readAddr,
	output picPkg::lineWord_t readData,
	input  logic              writeEn,
	input  picPkg::mbNumH_t   writeAddr,
	input  picPkg::lineWord_t writeData
);

	picPkg::lineWord_t mem [`MB_COLS];

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < `MB_COLS; i++)
				mem[i] <= '0;
			readData <= '0;
		end
		else
		begin
			if (writeEn)
				mem[writeAddr] <= writeData;
			readData <= mem[readAddr];  // old entry on a same-address write
		end
	end

	// column addresses from the fetch side never run past the picture
	addrInRange: assert property (@(posedge clk) disable iff (!reset_n)
		(readAddr < `MB_COLS) && (!writeEn || (writeAddr < `MB_COLS)));

endmodule

/* leftNeighbor/leftModeFetch.sv */
// left side of the intra 4x4 mode decoder, produces candidate A for the block being decoded
`timescale 1ns/100ps
`include "intra_consts.svh"

module leftModeFetch
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                accept,
	input  intraPkg::blkIdx_t   blkIdx,
	input  picPkg::mbNumH_t     mbNumH,
	input  intraPkg::mbType_t   mbType,
	input  logic                constrainedIntra,
	input  intraPkg::mbModes_t  currMbModes,
	input  logic                modeValid,
	input  intraPkg::predMode_t modeOut,
	input  intraPkg::blkIdx_t   blkIdxOut,
	output intraPkg::predMode_t candA,
	output logic                forceDcA
);

	intraPkg::blkIdx_t   curBlkIdx;
	picPkg::mbNumH_t     curMbNumH;
	intraPkg::mbType_t   curMbType;
	logic                curConstrained;
	intraPkg::predMode_t leftCol [4];  // right column of the left mb, top to bottom
	intraPkg::mbType_t   leftType;
	logic                fromLeftMb;
	logic                leftIsInter;
	intraPkg::blkIdx_t   nbIdx;        // neighbour A inside the current mb

	// block fields, held through stage 1
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			curBlkIdx      <= '0;
			curMbNumH      <= '0;
			curMbType      <= '0;
			curConstrained <= 1'b0;
		end
		else if (accept)
		begin
			curBlkIdx      <= blkIdx;
			curMbNumH      <= mbNumH;
			curMbType      <= mbType;
			curConstrained <= constrainedIntra;
		end
	end

	//----------------------------------------
	// left column store
	//----------------------------------------
	// blocks 5, 7, 13, 15 refill slots whose last reader (0, 2, 8, 10) is already done
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < 4; i++)
				leftCol[i] <= '0;
			leftType <= '0;
		end
		else if (modeValid)
		begin
			if (blkIdxOut[2] && blkIdxOut[0])  // 5, 7, 13, 15
				leftCol[{blkIdxOut[3], blkIdxOut[1]}] <= modeOut;
			if (blkIdxOut == 4'd15)
				leftType <= curMbType;  // becomes the left mb of the next one
		end
	end

	//----------------------------------------
	// stage 1, candidate A
	//----------------------------------------
	assign fromLeftMb = (curBlkIdx == 4'd0) || (curBlkIdx == 4'd2) ||
		(curBlkIdx == 4'd8) || (curBlkIdx == 4'd10);
	assign leftIsInter = (leftType == intraPkg::mbType_t'(`MBT_SKIP)) ||
		(leftType == intraPkg::mbType_t'(`MBT_INTER));
	assign forceDcA = fromLeftMb && ((curMbNumH == '0) || (curConstrained && leftIsInter));

	always_comb
	begin
		case (curBlkIdx)
			4'd1:    nbIdx = 4'd0;
			4'd3:    nbIdx = 4'd2;
			4'd4:    nbIdx = 4'd1;
			4'd5:    nbIdx = 4'd4;
			4'd6:    nbIdx = 4'd3;
			4'd7:    nbIdx = 4'd6;
			4'd9:    nbIdx = 4'd8;
			4'd11:   nbIdx = 4'd10;
			4'd12:   nbIdx = 4'd9;
			4'd13:   nbIdx = 4'd12;
			4'd14:   nbIdx = 4'd11;
			4'd15:   nbIdx = 4'd14;
			default: nbIdx = 4'd0;  // left mb case, not used
		endcase
	end

	always_comb
	begin
		if (!fromLeftMb)
			candA = currMbModes[{nbIdx, 2'b00} +: 4];
		else if (leftType != intraPkg::mbType_t'(`MBT_INTRA4X4))
			candA = intraPkg::predMode_t'(`DC_PRED_MODE);
		else
			candA = leftCol[{curBlkIdx[3], curBlkIdx[1]}];  // 0, 2, 8, 10 map to slots 0..3
	end

endmodule

/* common/picPkg.sv */
// picture geometry types used by the intra 4x4 mode decoder and its line buffer
package picPkg;

	typedef logic [3:0] mbNumH_t;  // macroblock column
	typedef logic [3:0] mbNumV_t;  // macroblock row

	// one line buffer entry, bottom row of a macroblock plus its type
	// [17:14] block 10, [13:10] block 11, [9:6] block 14, [5:2] block 15, [1:0] type
	typedef logic [17:0] lineWord_t;

endpackage

/* common/intraPkg.sv */
// mode-related vector types shared by the intra 4x4 mode decoder and its testbench
package intraPkg;

	// one Intra4x4 prediction mode, legal range 0 to 8
	typedef logic [3:0] predMode_t;

	// rem_intra4x4_pred_mode as parsed
	typedef logic [2:0] remMode_t;

	// 4x4 block index in scan order
	typedef logic [3:0] blkIdx_t;

	// sixteen modes of one macroblock, block k at bits 4k+3 down to 4k
	typedef logic [63:0] mbModes_t;

	// macroblock type class
	typedef logic [1:0] mbType_t;

endpackage

/* common/intra_consts.svh */
// picture geometry, DC mode and macroblock type codes; include wherever these constants are used
`ifndef INTRA_CONSTS_SVH
`define INTRA_CONSTS_SVH

//----------------------------------------
// QCIF picture, in macroblocks
//----------------------------------------
`define MB_COLS 11
`define MB_ROWS 9

// mode substituted when a neighbour is missing or not intra 4x4
`define DC_PRED_MODE 2

//----------------------------------------
// macroblock type classes
//----------------------------------------
// anything below MBT_INTRA4X4 counts as inter
`define MBT_SKIP       0
`define MBT_INTER      1
`define MBT_INTRA4X4   2
`define MBT_INTRA16X16 3

`endif
